/* Makefile */
# verilator build, run and lint of the icache testbench

VERILATOR  ?= verilator
TOP        := tb_icache
FILELIST   := project.f
OBJ_DIR    := obj_dir
PASS_MSG   := TEST OK
FLAGS      := --binary --assert --timing --timescale 1ns/1ps -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --assert --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* project.f */
rtl/ic_cfg_pkg.sv
rtl/ic_types_pkg.sv
rtl/ic_way_array.sv
rtl/ic_set_state.sv
rtl/ic_hit_select.sv
rtl/ic_mshr.sv
rtl/icache_top.sv
verification/icache_assert.sv
verification/tb_icache.sv

/* rtl/ic_cfg_pkg.sv */
// icache configuration
// cache geometry and fetch width shared by every block
package ic_cfg_pkg;

  ////////////////////////////////////////
  // instruction and pc widths
  ////////////////////////////////////////

  localparam int PC_BITS       = 32;
  localparam int INST_BITS     = 32;
  // byte offset below one instruction
  localparam int INST_BYTE_LOG = 2;

  ////////////////////////////////////////
  // line geometry
  ////////////////////////////////////////

  localparam int INSTS_IN_LINE = 4;
  localparam int LINE_BITS     = INSTS_IN_LINE * INST_BITS;
  // instruction offset within a line
  localparam int OFFSET_BITS   = $clog2(INSTS_IN_LINE);

  ////////////////////////////////////////
  // sets and ways
  ////////////////////////////////////////

  localparam int NUM_SETS      = 16;
  localparam int INDEX_BITS    = $clog2(NUM_SETS);
  // whatever is left above index and offset
  localparam int TAG_BITS      = PC_BITS - INDEX_BITS - OFFSET_BITS - INST_BYTE_LOG;
  localparam int NUM_WAYS      = 4;
  localparam int WAY_BITS      = $clog2(NUM_WAYS);

  // instructions handed to fetch per cycle
  localparam int FETCH_WIDTH   = 2;

endpackage

/* rtl/ic_hit_select.sv */
// icache hit select
// tag compare, hit way pick and extraction of the fetch slots
module ic_hit_select (
  input  logic                                                           fetch_req_i,
  input  ic_types_pkg::ic_addr_t                                         addr_i,
  input  ic_types_pkg::ic_tag_t [ic_cfg_pkg::NUM_WAYS-1:0]               tags_i,
  input  ic_types_pkg::ic_line_t [ic_cfg_pkg::NUM_WAYS-1:0]              lines_i,
  input  logic [ic_cfg_pkg::NUM_WAYS-1:0]                                valid_i,
  output logic                                                           hit_o,
  output logic [ic_cfg_pkg::FETCH_WIDTH-1:0][ic_cfg_pkg::INST_BITS-1:0] inst_o,
  output logic [ic_cfg_pkg::FETCH_WIDTH-1:0]                             inst_valid_o
);

  import ic_cfg_pkg::*;
  import ic_types_pkg::*;

  // per way match
  logic [NUM_WAYS-1:0] way_hit;
  // line of the lowest hitting way
  ic_line_t hit_line;
  // same line seen as instruction words
  logic [INSTS_IN_LINE-1:0][INST_BITS-1:0] hit_words;
  // position in the line of each slot, one spare bit for overrun
  logic [FETCH_WIDTH-1:0][OFFSET_BITS:0] slot_pos;
  logic [FETCH_WIDTH-1:0] slot_in_line;

  ////////////////////////////////////////
  // tag compare
  ////////////////////////////////////////

  always_comb
  begin
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      // no fetch means no hit
      way_hit[w] = fetch_req_i & valid_i[w] & (tags_i[w] == addr_i.tag);
    end
  end

  assign hit_o = |way_hit;

  // walk down so the lowest hitting way is taken last
  always_comb
  begin
    hit_line = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--)
    begin
      if (way_hit[w])
      begin
        hit_line = lines_i[w];
      end
    end
  end

  assign hit_words = hit_line;

  ////////////////////////////////////////
  // fetch slots
  ////////////////////////////////////////

  always_comb
  begin
    for (int k = 0; k < FETCH_WIDTH; k++)
    begin
      slot_pos[k]     = {1'b0, addr_i.offset} + (OFFSET_BITS + 1)'(k);
      slot_in_line[k] = slot_pos[k] < INSTS_IN_LINE;
      // slots past the end of the line read as zero
      if (slot_in_line[k])
      begin
        inst_o[k] = hit_words[slot_pos[k][OFFSET_BITS-1:0]];
      end
      else
      begin
        inst_o[k] = '0;
      end
      // slot 0 is always inside the line, later ones depend on offset
      inst_valid_o[k] = hit_o & slot_in_line[k];
    end
  end

endmodule

/* rtl/ic_mshr.sv */
// icache miss handling
// miss pulse, single mshr, memory request and fill capture
module ic_mshr (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            fetch_req_i,
  input  logic                            hit_i,
  input  ic_types_pkg::ic_addr_t          addr_i,
  input  logic [ic_cfg_pkg::WAY_BITS-1:0] victim_way_i,
  input  ic_types_pkg::ic_mem_resp_t      resp_i,
  output ic_types_pkg::ic_mem_req_t       req_o,
  output ic_types_pkg::ic_fill_t          fill_o
);

  import ic_cfg_pkg::*;
  import ic_types_pkg::*;

  // fetch address and victim of the previous cycle
  ic_addr_t            addr_q;
  logic [WAY_BITS-1:0] victim_q;

  // miss history
  logic miss_d1_q;
  logic miss_d2_q;
  logic miss_pulse;
  logic req_valid;

  // outstanding miss, valid bit marks it busy
  ic_mem_req_t mshr_q;
  logic        resp_match;

  // fill register
  logic                  fill_valid_q;
  logic [WAY_BITS-1:0]   fill_way_q;
  logic [INDEX_BITS-1:0] fill_index_q;
  ic_tag_t               fill_tag_q;
  ic_line_t              fill_data_q;

  ////////////////////////////////////////
  // miss detection
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    addr_q   <= addr_i;
    victim_q <= victim_way_i;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      miss_d1_q <= 1'b0;
      miss_d2_q <= 1'b0;
    end
    else
    begin
      // a fill clears the history so a pending miss pulses again
      miss_d1_q <= fetch_req_i & ~hit_i & ~fill_valid_q;
      miss_d2_q <= miss_d1_q & ~fill_valid_q;
    end
  end

  // first cycle of a miss run
  assign miss_pulse = miss_d1_q & ~miss_d2_q;
  // mshr free, or freed by the fill in this cycle
  assign req_valid  = miss_pulse & (~mshr_q.valid | fill_valid_q);

  always_comb
  begin
    req_o.valid = req_valid;
    req_o.tag   = addr_q.tag;
    req_o.index = addr_q.index;
    req_o.way   = victim_q;
  end

  ////////////////////////////////////////
  // mshr
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mshr_q <= '0;
    end
    else if (req_valid)
    begin
      // load, or reload when a fill completes alongside
      mshr_q <= req_o;
    end
    else if (fill_valid_q)
    begin
      mshr_q.valid <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // fill capture
  ////////////////////////////////////////

  // response must match the outstanding line
  assign resp_match = resp_i.valid & mshr_q.valid
                    & (resp_i.tag == mshr_q.tag)
                    & (resp_i.index == mshr_q.index);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fill_valid_q <= 1'b0;
    end
    else
    begin
      fill_valid_q <= resp_match;
    end
  end

  always_ff @(posedge clk)
  begin
    // way recorded at request time steers the write
    fill_way_q   <= mshr_q.way;
    fill_index_q <= mshr_q.index;
    fill_tag_q   <= mshr_q.tag;
    fill_data_q  <= resp_i.data;
  end

  always_comb
  begin
    fill_o.valid = fill_valid_q;
    fill_o.way   = fill_way_q;
    fill_o.index = fill_index_q;
    fill_o.tag   = fill_tag_q;
    fill_o.data  = fill_data_q;
  end

endmodule

/* rtl/ic_set_state.sv */
// icache set state
// valid bits and round-robin victim pointers per set
module ic_set_state (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [ic_cfg_pkg::INDEX_BITS-1:0] rd_index_i,
  input  logic                              flush_i,
  input  ic_types_pkg::ic_inv_t             inv_i,
  input  ic_types_pkg::ic_fill_t            fill_i,
  input  ic_types_pkg::ic_mem_req_t         req_i,
  output logic [ic_cfg_pkg::NUM_WAYS-1:0]   valid_o,
  output logic [ic_cfg_pkg::WAY_BITS-1:0]   victim_way_o
);

  import ic_cfg_pkg::*;

  // one valid bit per way of each set
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  // next way to replace in each set
  logic [WAY_BITS-1:0] rr_q [NUM_SETS];

  ////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < NUM_SETS; s++)
      begin
        valid_q[s] <= '0;
      end
    end
    else if (flush_i)
    begin
      // flush beats both invalidation and fill
      for (int s = 0; s < NUM_SETS; s++)
      begin
        valid_q[s] <= '0;
      end
    end
    else
    begin
      // new line becomes visible at this edge
      if (fill_i.valid)
      begin
        valid_q[fill_i.index][fill_i.way] <= 1'b1;
      end
      // later assignment so invalidation wins on the same line
      if (inv_i.valid)
      begin
        valid_q[inv_i.index][inv_i.way] <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // round-robin victim pointers
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < NUM_SETS; s++)
      begin
        rr_q[s] <= '0;
      end
    end
    else if (req_i.valid)
    begin
      // step only on an issued request, wraps at NUM_WAYS
      rr_q[req_i.index] <= rr_q[req_i.index] + 1'b1;
    end
  end

  // state of the set being looked up
  assign valid_o      = valid_q[rd_index_i];
  assign victim_way_o = rr_q[rd_index_i];

endmodule

/* rtl/ic_types_pkg.sv */
// icache types
// packed structs for pc fields, memory traffic, fills and invalidations
package ic_types_pkg;

  import ic_cfg_pkg::*;

  typedef logic [TAG_BITS-1:0]  ic_tag_t;
  typedef logic [LINE_BITS-1:0] ic_line_t;

  // pc without the byte offset, msb first
  typedef struct packed {
    ic_tag_t                tag;
    logic [INDEX_BITS-1:0]  index;
    logic [OFFSET_BITS-1:0] offset;
  } ic_addr_t;

  // line read request towards memory
  typedef struct packed {
    logic                  valid;
    ic_tag_t               tag;
    logic [INDEX_BITS-1:0] index;
    // victim way picked at request time
    logic [WAY_BITS-1:0]   way;
  } ic_mem_req_t;

  // line returned by memory
  typedef struct packed {
    logic                  valid;
    ic_tag_t               tag;
    logic [INDEX_BITS-1:0] index;
    ic_line_t              data;
  } ic_mem_resp_t;

  // invalidate one line by set and way
  typedef struct packed {
    logic                  valid;
    logic [INDEX_BITS-1:0] index;
    logic [WAY_BITS-1:0]   way;
  } ic_inv_t;

  // line write into the arrays
  typedef struct packed {
    logic                  valid;
    logic [WAY_BITS-1:0]   way;
    logic [INDEX_BITS-1:0] index;
    ic_tag_t               tag;
    ic_line_t              data;
  } ic_fill_t;

endpackage

/* rtl/ic_way_array.sv */
// icache way array
// one entry per way and set, all ways of a set read at once
module ic_way_array #(
  parameter type entry_t = ic_types_pkg::ic_line_t
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [ic_cfg_pkg::INDEX_BITS-1:0]     rd_index_i,
  input  logic                                  wr_en_i,
  input  logic [ic_cfg_pkg::WAY_BITS-1:0]       wr_way_i,
  input  logic [ic_cfg_pkg::INDEX_BITS-1:0]     wr_index_i,
  input  entry_t                                wr_data_i,
  output entry_t [ic_cfg_pkg::NUM_WAYS-1:0]     rd_data_o
);

  import ic_cfg_pkg::*;

  // storage organised by set so one read returns every way
  entry_t [NUM_WAYS-1:0] mem_q [NUM_SETS];

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      // start from a known array
      for (int s = 0; s < NUM_SETS; s++)
      begin
        mem_q[s] <= '0;
      end
    end
    else if (wr_en_i)
    begin
      // single entry at the given way and set
      mem_q[wr_index_i][wr_way_i] <= wr_data_i;
    end
  end

  ////////////////////////////////////////
  // read port
  ////////////////////////////////////////

  // combinational read of the whole set
  assign rd_data_o = mem_q[rd_index_i];

endmodule

/* rtl/icache_top.sv */
// icache top level
// four way set associative instruction cache for the fetch stage
module icache_top (
  input  logic                                                           clk,
  input  logic                                                           reset,
  input  logic                                                           fetch_req_i,
  input  logic [ic_cfg_pkg::PC_BITS-1:0]                                 pc_i,
  input  ic_types_pkg::ic_mem_resp_t                                     mem_resp_i,
  input  ic_types_pkg::ic_inv_t                                          inv_i,
  input  logic                                                           flush_i,
  output logic [ic_cfg_pkg::FETCH_WIDTH-1:0][ic_cfg_pkg::INST_BITS-1:0] inst_o,
  output logic [ic_cfg_pkg::FETCH_WIDTH-1:0]                             inst_valid_o,
  output ic_types_pkg::ic_mem_req_t                                      mem_req_o,
  output logic                                                           miss_o,
  output logic                                                           flush_done_o
);

  import ic_cfg_pkg::*;
  import ic_types_pkg::*;

  // pc split into tag, index and offset
  ic_addr_t pc_addr;

  // contents of the addressed set
  ic_tag_t  [NUM_WAYS-1:0] way_tags;
  ic_line_t [NUM_WAYS-1:0] way_lines;
  logic     [NUM_WAYS-1:0] set_valid;
  logic     [WAY_BITS-1:0] victim_way;

  logic     hit;
  ic_fill_t fill;

  // drop the byte offset
  assign pc_addr = ic_addr_t'(pc_i[PC_BITS-1:INST_BYTE_LOG]);

  ////////////////////////////////////////
  // arrays and set state
  ////////////////////////////////////////

  ic_way_array #(
    .entry_t (ic_tag_t)
  ) u_tag_array (
    .clk        (clk),
    .reset      (reset),
    .rd_index_i (pc_addr.index),
    .wr_en_i    (fill.valid),
    .wr_way_i   (fill.way),
    .wr_index_i (fill.index),
    .wr_data_i  (fill.tag),
    .rd_data_o  (way_tags)
  );

  ic_way_array #(
    .entry_t (ic_line_t)
  ) u_data_array (
    .clk        (clk),
    .reset      (reset),
    .rd_index_i (pc_addr.index),
    .wr_en_i    (fill.valid),
    .wr_way_i   (fill.way),
    .wr_index_i (fill.index),
    .wr_data_i  (fill.data),
    .rd_data_o  (way_lines)
  );

  ic_set_state u_set_state (
    .clk          (clk),
    .reset        (reset),
    .rd_index_i   (pc_addr.index),
    .flush_i      (flush_i),
    .inv_i        (inv_i),
    .fill_i       (fill),
    .req_i        (mem_req_o),
    .valid_o      (set_valid),
    .victim_way_o (victim_way)
  );

  ////////////////////////////////////////
  // lookup and miss handling
  ////////////////////////////////////////

  ic_hit_select u_hit_select (
    .fetch_req_i  (fetch_req_i),
    .addr_i       (pc_addr),
    .tags_i       (way_tags),
    .lines_i      (way_lines),
    .valid_i      (set_valid),
    .hit_o        (hit),
    .inst_o       (inst_o),
    .inst_valid_o (inst_valid_o)
  );

  ic_mshr u_mshr (
    .clk          (clk),
    .reset        (reset),
    .fetch_req_i  (fetch_req_i),
    .hit_i        (hit),
    .addr_i       (pc_addr),
    .victim_way_i (victim_way),
    .resp_i       (mem_resp_i),
    .req_o        (mem_req_o),
    .fill_o       (fill)
  );

  // miss seen by the pipeline is the request strobe
  assign miss_o = mem_req_o.valid;

  // flush completes one cycle after the strobe
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      flush_done_o <= 1'b0;
    end
    else
    begin
      flush_done_o <= flush_i;
    end
  end

endmodule

/* verification/icache_assert.sv */
// icache mshr protocol checks
// request spacing and fill timing, bound into the miss handler
module icache_assert (
  input logic                       clk,
  input logic                       reset,
  input ic_types_pkg::ic_mem_req_t  req_i,
  input ic_types_pkg::ic_mem_req_t  mshr_i,
  input ic_types_pkg::ic_mem_resp_t resp_i,
  input ic_types_pkg::ic_fill_t     fill_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // a miss run pulses once
  req_spaced: assert property (@(posedge clk) disable iff (reset)
    req_i.valid |=> !req_i.valid)
    else $error("memory request strobe high in two consecutive cycles");

  fill_needs_mshr: assert property (@(posedge clk) disable iff (reset)
    fill_i.valid |-> mshr_i.valid)
    else $error("fill strobe while no miss is outstanding");

  // fill carries the line and address of the response one cycle back
  // and the way held by the mshr at that time
  fill_after_resp: assert property (@(posedge clk) disable iff (reset)
    fill_i.valid |-> $past(resp_i.valid) && $past(mshr_i.valid)
                     && (fill_i.tag == $past(resp_i.tag))
                     && (fill_i.index == $past(resp_i.index))
                     && (fill_i.data == $past(resp_i.data))
                     && (fill_i.way == $past(mshr_i.way)))
    else $error("fill strobe without a matching response one cycle earlier");

endmodule

bind ic_mshr icache_assert u_icache_assert (
  .clk    (clk),
  .reset  (reset),
  .req_i  (req_o),
  .mshr_i (mshr_q),
  .resp_i (resp_i),
  .fill_i (fill_o)
);

/* verification/tb_icache.sv */
// icache testbench
// random fetch, invalidation and flush traffic checked against a reference model
module tb_icache;
  timeunit 1ns;
  timeprecision 1ps;

  import ic_cfg_pkg::*;
  import ic_types_pkg::*;

  localparam int NUM_CYCLES  = 3000;
  localparam int MISS_LIMIT  = 100;
  localparam int DRAIN_LIMIT = 64;

  // dut ports
  logic                                  clk;
  logic                                  reset;
  logic                                  fetch_req;
  logic [PC_BITS-1:0]                    pc;
  ic_mem_resp_t                          mem_resp;
  ic_inv_t                               inv;
  logic                                  flush;
  logic [FETCH_WIDTH-1:0][INST_BITS-1:0] inst;
  logic [FETCH_WIDTH-1:0]                inst_valid;
  ic_mem_req_t                           mem_req;
  logic                                  miss;
  logic                                  flush_done;

  // reference model, state as seen after the next edge
  ic_tag_t               m_tag [NUM_SETS][NUM_WAYS];
  logic                  m_valid [NUM_SETS][NUM_WAYS];
  logic [WAY_BITS-1:0]   m_rr [NUM_SETS];
  logic                  m_miss1;
  logic                  m_miss2;
  logic                  m_flush_d;
  ic_mem_req_t           m_mshr;
  ic_fill_t              m_fill;
  ic_tag_t               m_prev_tag;
  logic [INDEX_BITS-1:0] m_prev_idx;

  // memory responder, at most one line in flight
  int                    resp_cnt;
  ic_tag_t               resp_tag;
  logic [INDEX_BITS-1:0] resp_idx;

  integer seed;
  int     check_count;
  int     err_count;
  int     hit_count;
  int     req_count;
  int     miss_run;
  logic   last_miss;
  logic   timed_out;
  logic   drained;
  string  why;

  icache_top UUT (
    .clk          (clk),
    .reset        (reset),
    .fetch_req_i  (fetch_req),
    .pc_i         (pc),
    .mem_resp_i   (mem_resp),
    .inv_i        (inv),
    .flush_i      (flush),
    .inst_o       (inst),
    .inst_valid_o (inst_valid),
    .mem_req_o    (mem_req),
    .miss_o       (miss),
    .flush_done_o (flush_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // line contents and address pool
  ////////////////////////////////////////

  // six tags over four sets so lines fight for ways
  function automatic ic_tag_t pool_tag(input int n);
    return ic_tag_t'(32'h005a_0000 + n * 32'h111);
  endfunction

  // word built from tag, set and position
  function automatic logic [INST_BITS-1:0] line_word(input ic_tag_t t,
                                                     input logic [INDEX_BITS-1:0] idx,
                                                     input int p);
    return {t[15:0], idx, p[1:0], 10'h2c5};
  endfunction

  function automatic ic_line_t make_line(input ic_tag_t t, input logic [INDEX_BITS-1:0] idx);
    ic_line_t l;
    for (int p = 0; p < INSTS_IN_LINE; p++)
    begin
      l[p*INST_BITS +: INST_BITS] = line_word(t, idx, p);
    end
    return l;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] got,
                          input logic [63:0] expected);
    check_count++;
    assert (got === expected)
    else
    begin
      err_count++;
      $display("MISMATCH time %0t %s got %0h expected %0h", $time, name, got, expected);
    end
  endtask

  ////////////////////////////////////////
  // stimulus and memory
  ////////////////////////////////////////

  task automatic drive_inputs(input logic quiet);
    ic_mem_resp_t resp;
    ic_inv_t      inv_n;
    logic [31:0]  r;
    logic [31:0]  r2;
    resp  = '0;
    inv_n = '0;
    r     = $random(seed);
    r2    = $random(seed);
    // answer once the delay runs out
    if (resp_cnt > 0)
    begin
      resp_cnt--;
      if (resp_cnt == 0)
      begin
        resp.valid = 1'b1;
        resp.tag   = resp_tag;
        resp.index = resp_idx;
        resp.data  = make_line(resp_tag, resp_idx);
      end
      else if (!quiet && r[27:25] == 3'd0)
      begin
        // near miss with the tag or the set off by the top bit
        resp.valid = 1'b1;
        resp.tag   = resp_tag;
        resp.index = resp_idx;
        if (r[28])
        begin
          resp.tag = {~resp_tag[TAG_BITS-1], resp_tag[TAG_BITS-2:0]};
        end
        else
        begin
          resp.index = {~resp_idx[INDEX_BITS-1], resp_idx[INDEX_BITS-2:0]};
        end
        resp.data = make_line(resp.tag, resp.index);
      end
    end
    mem_resp  <= resp;
    fetch_req <= !quiet && (r[2:0] != 3'd0);
    // a missing fetch is mostly replayed
    if (!quiet && (!last_miss || r[5:3] == 3'd0))
    begin
      pc <= {pool_tag(int'(r2[15:8]) % 6), INDEX_BITS'(r2[1:0]), r2[3:2], r2[5:4]};
    end
    if (!quiet && r[10:6] == 5'd0)
    begin
      inv_n.valid = 1'b1;
      inv_n.index = INDEX_BITS'(r[12:11]);
      inv_n.way   = r[14:13];
    end
    inv   <= inv_n;
    flush <= !quiet && (r[23:16] < 8'd2);
  endtask

  ////////////////////////////////////////
  // checks and model step
  ////////////////////////////////////////

  task automatic check_and_step();
    ic_tag_t               tag;
    logic [INDEX_BITS-1:0] idx;
    int                    off;
    int                    pos;
    logic                  exp_hit;
    logic                  exp_req;
    logic [WAY_BITS-1:0]   req_way;
    logic [FETCH_WIDTH-1:0] exp_iv;
    logic [INST_BITS-1:0]  exp_word;
    ic_fill_t              fill_n;
    tag = pc[PC_BITS-1 -: TAG_BITS];
    idx = pc[INST_BYTE_LOG + OFFSET_BITS +: INDEX_BITS];
    off = int'(pc[INST_BYTE_LOG +: OFFSET_BITS]);
    exp_hit = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      if (fetch_req && m_valid[idx][w] && m_tag[idx][w] == tag)
      begin
        exp_hit = 1'b1;
      end
    end
    // slots past the line end stay invalid and read zero
    for (int k = 0; k < FETCH_WIDTH; k++)
    begin
      pos       = off + k;
      exp_iv[k] = exp_hit && (pos < INSTS_IN_LINE);
      if (exp_hit)
      begin
        exp_word = (pos < INSTS_IN_LINE) ? line_word(tag, idx, pos) : '0;
        check_eq($sformatf("inst_o[%0d]", k), 64'(inst[k]), 64'(exp_word));
      end
    end
    check_eq("inst_valid_o", 64'(inst_valid), 64'(exp_iv));
    // first cycle of a miss run, mshr free or filling
    exp_req = m_miss1 && !m_miss2 && (!m_mshr.valid || m_fill.valid);
    req_way = m_rr[m_prev_idx];
    check_eq("mem_req_o.valid", 64'(mem_req.valid), 64'(exp_req));
    check_eq("miss_o", 64'(miss), 64'(exp_req));
    if (exp_req)
    begin
      check_eq("mem_req_o.tag", 64'(mem_req.tag), 64'(m_prev_tag));
      check_eq("mem_req_o.index", 64'(mem_req.index), 64'(m_prev_idx));
      check_eq("mem_req_o.way", 64'(mem_req.way), 64'(req_way));
    end
    check_eq("flush_done_o", 64'(flush_done), 64'(m_flush_d));
    if (mem_req.valid)
    begin
      req_count++;
      check_count++;
      assert (resp_cnt == 0)
      else
      begin
        err_count++;
        $display("memory got a new request at %0t with one still outstanding", $time);
      end
      resp_cnt = 1 + int'({$random(seed)} % 6);
      resp_tag = mem_req.tag;
      resp_idx = mem_req.index;
    end
    // response matching the mshr fills next cycle
    fill_n       = '0;
    fill_n.valid = mem_resp.valid && m_mshr.valid && mem_resp.tag == m_mshr.tag
                   && mem_resp.index == m_mshr.index;
    fill_n.way   = m_mshr.way;
    fill_n.index = m_mshr.index;
    fill_n.tag   = m_mshr.tag;
    if (m_fill.valid)
    begin
      m_tag[m_fill.index][m_fill.way] = m_fill.tag;
    end
    if (flush)
    begin
      for (int s = 0; s < NUM_SETS; s++)
      begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
          m_valid[s][w] = 1'b0;
        end
      end
    end
    else
    begin
      if (m_fill.valid)
      begin
        m_valid[m_fill.index][m_fill.way] = 1'b1;
      end
      if (inv.valid)
      begin
        m_valid[inv.index][inv.way] = 1'b0;
      end
    end
    if (exp_req)
    begin
      m_rr[m_prev_idx] = req_way + 1'b1;
      m_mshr.valid     = 1'b1;
      m_mshr.tag       = m_prev_tag;
      m_mshr.index     = m_prev_idx;
      m_mshr.way       = req_way;
    end
    else if (m_fill.valid)
    begin
      m_mshr.valid = 1'b0;
    end
    m_miss2    = m_miss1 && !m_fill.valid;
    m_miss1    = fetch_req && !exp_hit && !m_fill.valid;
    m_fill     = fill_n;
    m_prev_tag = tag;
    m_prev_idx = idx;
    m_flush_d  = flush;
    if (exp_hit)
    begin
      hit_count++;
    end
    last_miss = fetch_req && !exp_hit;
    miss_run  = last_miss ? miss_run + 1 : 0;
    if (miss_run > MISS_LIMIT)
    begin
      timed_out = 1'b1;
      why       = "a fetch kept missing and no fill brought its line in";
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    seed      = 32'h0be5dbe1;
    reset     = 1'b1;
    fetch_req = 1'b0;
    pc        = '0;
    mem_resp  = '0;
    inv       = '0;
    flush     = 1'b0;
    m_miss1   = 1'b0;
    m_miss2   = 1'b0;
    m_flush_d = 1'b0;
    m_mshr    = '0;
    m_fill    = '0;
    resp_cnt  = 0;
    miss_run  = 0;
    last_miss = 1'b0;
    timed_out = 1'b0;
    drained   = 1'b0;
    for (int s = 0; s < NUM_SETS; s++)
    begin
      m_rr[s] = '0;
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        m_tag[s][w]   = '0;
        m_valid[s][w] = 1'b0;
      end
    end
    for (int c = 0; c < 16; c++)
    begin
      @(posedge clk);
    end
    reset <= 1'b0;
    // drive on the rising edge, check at the falling edge
    for (int c = 0; c < NUM_CYCLES && !timed_out; c++)
    begin
      @(posedge clk);
      drive_inputs(1'b0);
      @(negedge clk);
      check_and_step();
    end
    // let the last miss complete
    for (int c = 0; c < DRAIN_LIMIT && !drained && !timed_out; c++)
    begin
      @(posedge clk);
      drive_inputs(1'b1);
      @(negedge clk);
      check_and_step();
      drained = resp_cnt == 0 && !m_mshr.valid && !m_fill.valid && !m_miss1;
    end
    if (!drained && !timed_out)
    begin
      timed_out = 1'b1;
      why       = "the outstanding miss did not drain in time";
    end
    if (timed_out)
    begin
      $display("timeout at %0t: %s", $time, why);
    end
    $display("checks %0d errors %0d hits %0d requests %0d",
             check_count, err_count, hit_count, req_count);
    if (err_count == 0 && !timed_out)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
